// File: bench/router_stim.txt
// Columns: source nibble, channel nibble, 32-bit flit word; one flit per line.
// Head word: type, dest, pkt_size, tag whose top nibble is the source.
0120200001
014000A001
018000A002
0010000002
0030100003
008000A031
1020210001
104001B001
108001B002
1120110002
118001B021
1010010003
2020120001
208002C001
2100320002
214002C021
214002C022
218002C023
3010030001
3120230002
314003D021
318003D022
3000130003
308003D031

// File: router.f
hw/noc_pkg.sv
hw/rr_arbiter.sv
hw/input_stage.sv
hw/output_module.sv
hw/egress_stage.sv
hw/router_top.sv
bench/router_checker.sv
bench/router_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the router testbench with Verilator, runs it, and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module router_tb -f router.f -o router_sim \
  > build.log 2>&1 \
  && ./obj_dir/router_sim +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "build or run ended abnormally"
grep -q "ALL CHECKS PASSED" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log and build.log"; exit 1; }

// File: bench/router_tb.sv
// Router testbench: plays the packets of the stim file into the inputs and checks every output flit.
`timescale 1ns/1ns
`default_nettype none

module router_tb;

  localparam int N_FLITS     = 24;
  localparam int CYCLE_LIMIT = 8 * N_FLITS * 4 + 200;

  logic clk;
  logic reset_i;
  noc_pkg::s_flit_req_t  [noc_pkg::N_PORTS-1:0] in_req;
  noc_pkg::s_flit_resp_t [noc_pkg::N_PORTS-1:0] in_resp;
  noc_pkg::s_flit_req_t  [noc_pkg::N_PORTS-1:0] out_req;
  noc_pkg::s_flit_resp_t [noc_pkg::N_PORTS-1:0] out_resp;

  // Table entry is {source nibble, channel nibble, flit word}.
  logic [39:0] stim_mem [N_FLITS];
  // Table indices still to be sent, one queue per source.
  int          src_q [noc_pkg::N_PORTS][$];
  // Expected flits keyed by output, channel and source.
  logic [31:0] exp_q [32][$];
  // Source of the packet now open on each output and channel.
  logic [3:0]  cur_src [8];
  logic [31:0] lfsr_q;
  int          flits_out;
  int          cycles;
  int          cat_err [2];

  router_top dut0 (
    .clk        (clk),
    .reset_i    (reset_i),
    .in_req_i   (in_req),
    .in_resp_o  (in_resp),
    .out_req_o  (out_req),
    .out_resp_i (out_resp)
  );

  always #20 clk = ~clk;

  // Galois LFSR that steps once for each random bit it hands out.
  function automatic logic draw_bit();
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    return lfsr_q[0];
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input int cat,
                       input string msg);
    if (got !== exp) begin
      $display("FAILED %0t: %s (got %h, expected %h)", $time, msg, got, exp);
      cat_err[cat]++;
    end
  endtask

  function automatic int exp_key(input int o, input int v, input int s);
    return o * 8 + v * 4 + s;
  endfunction

  // Splits the table per source and sorts each flit under the dest of its packet's head.
  task automatic load_stim();
    noc_pkg::flit_data_u f;
    int s;
    int dest_of [noc_pkg::N_PORTS];
    $readmemh("bench/router_stim.txt", stim_mem);
    for (int i = 0; i < N_FLITS; i++) begin
      s = int'(stim_mem[i][37:36]);
      f = stim_mem[i][31:0];
      if (f.head.type_f == noc_pkg::HEAD_FLIT) begin
        dest_of[s] = int'(f.head.dest);
      end
      src_q[s].push_back(i);
      exp_q[exp_key(dest_of[s], int'(stim_mem[i][32]), s)].push_back(stim_mem[i][31:0]);
    end
  endtask

  // Puts the source's next flit on its link when the LFSR allows, else drops valid.
  task automatic offer(input int s);
    logic b;
    int   idx;
    b = draw_bit();
    if (src_q[s].size() != 0 && b) begin
      idx = src_q[s][0];
      in_req[s].valid <= 1'b1;
      in_req[s].vc_id <= stim_mem[idx][32];
      in_req[s].fdata <= stim_mem[idx][31:0];
    end else begin
      in_req[s].valid <= 1'b0;
    end
  endtask

  // A head flit opens a packet on its channel; the source id sits in the tag's top nibble.
  task automatic take_flit(input int o);
    noc_pkg::flit_data_u f;
    int v;
    int key;
    f = out_req[o].fdata;
    v = int'(out_req[o].vc_id);
    if (f.head.type_f == noc_pkg::HEAD_FLIT) begin
      cur_src[o * 2 + v] = f.head.tag[19:16];
    end
    key = exp_key(o, v, int'(cur_src[o * 2 + v]));
    if (exp_q[key].size() == 0) begin
      check(32'd0, 32'd1, 0, $sformatf("unexpected flit %h on port %0d vc %0d", f, o, v));
    end else begin
      check(f, exp_q[key].pop_front(), 1, $sformatf("flit on port %0d vc %0d", o, v));
    end
    flits_out++;
  endtask

  // Samples the links at the edge, then drives the next cycle's inputs.
  always @(posedge clk) begin : drive_and_monitor
    if (!reset_i) begin
      cycles++;
      for (int o = 0; o < noc_pkg::N_PORTS; o++) begin
        if (out_req[o].valid && out_resp[o].ready) begin
          take_flit(o);
        end
      end
      for (int s = 0; s < noc_pkg::N_PORTS; s++) begin
        if (in_req[s].valid && in_resp[s].ready) begin
          void'(src_q[s].pop_front());
          offer(s);
        end else if (!in_req[s].valid) begin
          offer(s);
        end
      end
      for (int o = 0; o < noc_pkg::N_PORTS; o++) begin
        out_resp[o].ready <= draw_bit();
      end
    end
  end

  initial begin : run
    int total;
    clk       = 1'b0;
    reset_i   = 1'b1;
    in_req    = '0;
    out_resp  = '0;
    lfsr_q    = 32'h6f85bd68;
    flits_out = 0;
    cycles    = 0;
    cat_err   = '{0, 0};
    for (int k = 0; k < 8; k++) begin
      cur_src[k] = '0;
    end
    load_stim();
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;
    while (flits_out < N_FLITS && cycles < CYCLE_LIMIT) begin
      @(negedge clk);
    end
    if (cycles >= CYCLE_LIMIT) begin
      $display("Router stalled: %0d of %0d flits out after %0d cycles",
               flits_out, N_FLITS, cycles);
      $display("CHECKS FAILED");
      $finish;
    end else begin
      // Extra cycles expose any duplicated flit.
      repeat (10) @(negedge clk);
      check(flits_out, N_FLITS, 0, "flit count at the outputs");
      total = cat_err[0] + cat_err[1] + dut0.u_router_checker.fail_cnt;
      $display("routing and flit count: %0d errors", cat_err[0]);
      $display("packet contiguity, order and data: %0d errors", cat_err[1]);
      $display("link hold, reset and channel priority: %0d failures",
               dut0.u_router_checker.fail_cnt);
      $display("summary: %0d flits in, %0d flits out, %0d errors", N_FLITS, flits_out, total);
      if (total == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: bench/router_checker.sv
// Handshake and channel priority assertions, bound into router_top for every simulation of it.
`timescale 1ns/1ns
`default_nettype none

module router_checker (
  input logic                                                               clk,
  input logic                                                               reset_i,
  input noc_pkg::s_flit_resp_t [noc_pkg::N_PORTS-1:0]                       in_resp_i,
  input noc_pkg::s_flit_req_t  [noc_pkg::N_PORTS-1:0]                       om_req_i,
  input noc_pkg::s_flit_req_t  [noc_pkg::N_PORTS-1:0]                       out_req_i,
  input noc_pkg::s_flit_resp_t [noc_pkg::N_PORTS-1:0]                       out_resp_i,
  input logic [noc_pkg::N_PORTS-1:0][noc_pkg::N_VIRT_CHN-1:0][noc_pkg::N_PORTS-1:0] vc_req_i,
  input logic [noc_pkg::N_PORTS-1:0][noc_pkg::N_VIRT_CHN-1:0][noc_pkg::N_PORTS-1:0] vc_grant_i
);

  // The testbench adds this count of assertion failures to its own errors.
  int fail_cnt = 0;

  for (genvar p = 0; p < noc_pkg::N_PORTS; p++) begin : g_port
    // An output flit that is not taken stays on the link unchanged.
    a_out_hold : assert property (@(posedge clk) disable iff (reset_i)
      out_req_i[p].valid && !out_resp_i[p].ready |=>
        out_req_i[p].valid && $stable(out_req_i[p].fdata) && $stable(out_req_i[p].vc_id))
      else begin
        $error("output %0d changed its flit before the sink took it", p);
        fail_cnt++;
      end

    // A granted channel-1 flit always owns the output over channel 0.
    a_vc_prio : assert property (@(posedge clk) disable iff (reset_i)
      |(vc_req_i[p][1] & vc_grant_i[p][1]) |-> om_req_i[p].valid && (om_req_i[p].vc_id == 1'b1))
      else begin
        $error("output %0d let channel 0 pass a granted channel 1 flit", p);
        fail_cnt++;
      end

    // Every reset edge leaves the links idle.
    a_reset_idle : assert property (@(posedge clk)
      reset_i |=> !out_req_i[p].valid && !in_resp_i[p].ready)
      else begin
        $error("port %0d not idle after reset", p);
        fail_cnt++;
      end
  end

endmodule

bind router_top router_checker u_router_checker (
  .clk        (clk),
  .reset_i    (reset_i),
  .in_resp_i  (in_resp_o),
  .om_req_i   (om_req),
  .out_req_i  (out_req_o),
  .out_resp_i (out_resp_i),
  .vc_req_i   ({g_out[3].u_output_module.req_vc, g_out[2].u_output_module.req_vc,
                g_out[1].u_output_module.req_vc, g_out[0].u_output_module.req_vc}),
  .vc_grant_i ({g_out[3].u_output_module.grant_vc, g_out[2].u_output_module.grant_vc,
                g_out[1].u_output_module.grant_vc, g_out[0].u_output_module.grant_vc})
);

`default_nettype wire

// File: hw/router_top.sv
// Four-port wormhole router with virtual channels; the top that the testbench instantiates.
`timescale 1ns/1ns
`default_nettype none

module router_top (
  input  logic                                         clk,
  input  logic                                         reset_i,
  input  noc_pkg::s_flit_req_t  [noc_pkg::N_PORTS-1:0] in_req_i,
  output noc_pkg::s_flit_resp_t [noc_pkg::N_PORTS-1:0] in_resp_o,
  output noc_pkg::s_flit_req_t  [noc_pkg::N_PORTS-1:0] out_req_o,
  input  noc_pkg::s_flit_resp_t [noc_pkg::N_PORTS-1:0] out_resp_i
);

  // Crossbar requests and responses.
  // Both are indexed by output first and then by input.
  noc_pkg::s_flit_req_t  [noc_pkg::N_PORTS-1:0][noc_pkg::N_PORTS-1:0] im_req;
  noc_pkg::s_flit_resp_t [noc_pkg::N_PORTS-1:0][noc_pkg::N_PORTS-1:0] im_resp;

  // Links between the output modules and the egress buffers.
  noc_pkg::s_flit_req_t  [noc_pkg::N_PORTS-1:0] om_req;
  noc_pkg::s_flit_resp_t [noc_pkg::N_PORTS-1:0] om_resp;

  input_stage u_input_stage (
    .clk       (clk),
    .reset_i   (reset_i),
    .in_req_i  (in_req_i),
    .in_resp_o (in_resp_o),
    .om_req_o  (im_req),
    .om_resp_i (im_resp)
  );

  // One output module per port, each seeing every input's request toward it.
  for (genvar o = 0; o < noc_pkg::N_PORTS; o++) begin : g_out
    output_module u_output_module (
      .clk         (clk),
      .reset_i     (reset_i),
      .fin_req_i   (im_req[o]),
      .fin_resp_o  (im_resp[o]),
      .fout_req_o  (om_req[o]),
      .fout_resp_i (om_resp[o])
    );
  end

  egress_stage u_egress_stage (
    .clk        (clk),
    .reset_i    (reset_i),
    .om_req_i   (om_req),
    .om_resp_o  (om_resp),
    .out_req_o  (out_req_o),
    .out_resp_i (out_resp_i)
  );

endmodule

`default_nettype wire

// File: hw/egress_stage.sv
// Router output side: per-port flit buffers that drive the external links.
`timescale 1ns/1ns
`default_nettype none

module egress_stage (
  input  logic                                         clk,
  input  logic                                         reset_i,
  input  noc_pkg::s_flit_req_t  [noc_pkg::N_PORTS-1:0] om_req_i,
  output noc_pkg::s_flit_resp_t [noc_pkg::N_PORTS-1:0] om_resp_o,
  output noc_pkg::s_flit_req_t  [noc_pkg::N_PORTS-1:0] out_req_o,
  input  noc_pkg::s_flit_resp_t [noc_pkg::N_PORTS-1:0] out_resp_i
);

  for (genvar o = 0; o < noc_pkg::N_PORTS; o++) begin : g_out

    noc_pkg::flit_data_u            mem_data_q [noc_pkg::FIFO_DEPTH];
    logic [noc_pkg::VC_W-1:0]       mem_vc_q   [noc_pkg::FIFO_DEPTH];
    logic [noc_pkg::FIFO_PTR_W-1:0] wr_ptr_q;
    logic [noc_pkg::FIFO_PTR_W-1:0] rd_ptr_q;
    logic [noc_pkg::FIFO_CNT_W-1:0] count_q;
    logic [noc_pkg::FIFO_CNT_W-1:0] count_nxt;
    logic                           ready_q;
    logic                           push;
    logic                           pop;

    assign push = om_req_i[o].valid && ready_q;
    assign pop  = (count_q != '0) && out_resp_i[o].ready;

    always_comb begin
      count_nxt = count_q;
      if (push && !pop) begin
        count_nxt = count_q + 1'b1;
      end else if (!push && pop) begin
        count_nxt = count_q - 1'b1;
      end
    end

    always_ff @(posedge clk) begin
      if (push) begin
        mem_data_q[wr_ptr_q] <= om_req_i[o].fdata;
        mem_vc_q[wr_ptr_q]   <= om_req_i[o].vc_id;
      end
    end

    // Ready toward the arbiters is a flop, so the sink's ready never reaches them.
    always_ff @(posedge clk) begin
      if (reset_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
        ready_q  <= 1'b0;
      end else begin
        count_q <= count_nxt;
        ready_q <= (count_nxt < noc_pkg::FIFO_DEPTH);
        if (push) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
    end

    assign om_resp_o[o].ready = ready_q;

    // The front entry stays put until the sink takes it.
    assign out_req_o[o].valid = (count_q != '0);
    assign out_req_o[o].vc_id = mem_vc_q[rd_ptr_q];
    assign out_req_o[o].fdata = mem_data_q[rd_ptr_q];
  end

endmodule

`default_nettype wire

// File: hw/output_module.sv
// One router output: per-channel round-robin arbitration and the mux onto the output link.
`timescale 1ns/1ns
`default_nettype none

module output_module (
  input  logic                                         clk,
  input  logic                                         reset_i,
  input  noc_pkg::s_flit_req_t  [noc_pkg::N_PORTS-1:0] fin_req_i,
  output noc_pkg::s_flit_resp_t [noc_pkg::N_PORTS-1:0] fin_resp_o,
  output noc_pkg::s_flit_req_t                         fout_req_o,
  input  noc_pkg::s_flit_resp_t                        fout_resp_i
);

  // Requests and grants, one vector of inputs per virtual channel.
  logic [noc_pkg::N_VIRT_CHN-1:0][noc_pkg::N_PORTS-1:0] req_vc;
  logic [noc_pkg::N_VIRT_CHN-1:0][noc_pkg::N_PORTS-1:0] grant_vc;
  logic [noc_pkg::N_VIRT_CHN-1:0]                       update_vc;

  // The channel and input that own the output this cycle.
  logic                        act_vld;
  logic [noc_pkg::VC_W-1:0]    act_vc;
  logic [noc_pkg::PORT_W-1:0]  act_in;
  noc_pkg::flit_data_u         act_flit;
  logic                        act_last;

  for (genvar v = 0; v < noc_pkg::N_VIRT_CHN; v++) begin : g_vc
    rr_arbiter u_rr_arbiter (
      .clk      (clk),
      .reset_i  (reset_i),
      .update_i (update_vc[v]),
      .req_i    (req_vc[v]),
      .grant_o  (grant_vc[v])
    );
  end

  // Sort the valid inputs into their channel's request vector.
  always_comb begin : sort_requests
    req_vc = '0;
    for (int i = 0; i < noc_pkg::N_PORTS; i++) begin
      for (int v = 0; v < noc_pkg::N_VIRT_CHN; v++) begin
        if (fin_req_i[i].valid && (fin_req_i[i].vc_id == v[noc_pkg::VC_W-1:0])) begin
          req_vc[v][i] = 1'b1;
        end
      end
    end
  end

  // Pick a channel whose granted input has a flit ready.
  // A channel whose locked input is between flits does not block the other channel.
  always_comb begin : select_channel
    act_vld = 1'b0;
    act_vc  = '0;
    if (noc_pkg::H_PRIORITY) begin
      // Ascending scan, the highest channel is written last and wins.
      for (int v = 0; v < noc_pkg::N_VIRT_CHN; v++) begin
        if (|(grant_vc[v] & req_vc[v])) begin
          act_vld = 1'b1;
          act_vc  = v[noc_pkg::VC_W-1:0];
        end
      end
    end else begin
      for (int v = noc_pkg::N_VIRT_CHN - 1; v >= 0; v--) begin
        if (|(grant_vc[v] & req_vc[v])) begin
          act_vld = 1'b1;
          act_vc  = v[noc_pkg::VC_W-1:0];
        end
      end
    end

    // Grants are one-hot, so the scan order here does not matter.
    act_in = '0;
    for (int i = 0; i < noc_pkg::N_PORTS; i++) begin
      if (grant_vc[act_vc][i]) begin
        act_in = i[noc_pkg::PORT_W-1:0];
      end
    end
  end

  assign act_flit = fin_req_i[act_in].fdata;
  assign act_last = (act_flit.body.type_f == noc_pkg::TAIL_FLIT) ||
                    ((act_flit.head.type_f == noc_pkg::HEAD_FLIT) &&
                     (act_flit.head.pkt_size == noc_pkg::MIN_SIZE_FLIT));

  // Forward the winner and give the link's ready back to it alone.
  always_comb begin : output_mux
    fout_req_o.valid = act_vld;
    fout_req_o.vc_id = act_vc;
    fout_req_o.fdata = act_flit;
    fin_resp_o = '0;
    fin_resp_o[act_in].ready = act_vld && fout_resp_i.ready;
  end

  // Release a channel's arbiter on the edge where its packet's last flit transfers.
  always_comb begin : release_pulse
    update_vc = '0;
    update_vc[act_vc] = act_vld && fout_resp_i.ready && act_last;
  end

endmodule

`default_nettype wire

// File: hw/input_stage.sv
// Router input side: per-port flit FIFOs that route each packet to the output named in its head.
`timescale 1ns/1ns
`default_nettype none

module input_stage (
  input  logic                                                 clk,
  input  logic                                                 reset_i,
  input  noc_pkg::s_flit_req_t  [noc_pkg::N_PORTS-1:0]                        in_req_i,
  output noc_pkg::s_flit_resp_t [noc_pkg::N_PORTS-1:0]                        in_resp_o,
  output noc_pkg::s_flit_req_t  [noc_pkg::N_PORTS-1:0][noc_pkg::N_PORTS-1:0]  om_req_o,
  input  noc_pkg::s_flit_resp_t [noc_pkg::N_PORTS-1:0][noc_pkg::N_PORTS-1:0]  om_resp_i
);

  for (genvar i = 0; i < noc_pkg::N_PORTS; i++) begin : g_in

    // Flit storage.
    // Only the channel id and the flit word are kept, valid is implied by the count.
    noc_pkg::flit_data_u          mem_data_q [noc_pkg::FIFO_DEPTH];
    logic [noc_pkg::VC_W-1:0]     mem_vc_q   [noc_pkg::FIFO_DEPTH];
    logic [noc_pkg::FIFO_PTR_W-1:0] wr_ptr_q;
    logic [noc_pkg::FIFO_PTR_W-1:0] rd_ptr_q;
    logic [noc_pkg::FIFO_CNT_W-1:0] count_q;
    logic [noc_pkg::FIFO_CNT_W-1:0] count_nxt;
    logic                         ready_q;
    logic                         push;
    logic                         pop;

    // Route held between a head flit and its packet's last flit.
    logic [noc_pkg::PORT_W-1:0]   route_q;
    logic                         route_vld_q;

    // Decode of the flit at the front of the FIFO.
    noc_pkg::flit_data_u          front;
    logic                         front_head;
    logic                         front_last;
    logic                         front_vld;
    logic [noc_pkg::PORT_W-1:0]   cur_dest;
    logic                         out_rdy;

    assign push = in_req_i[i].valid && ready_q;
    assign pop  = front_vld && out_rdy;

    always_comb begin
      count_nxt = count_q;
      if (push && !pop) begin
        count_nxt = count_q + 1'b1;
      end else if (!push && pop) begin
        count_nxt = count_q - 1'b1;
      end
    end

    assign front      = mem_data_q[rd_ptr_q];
    assign front_head = (front.head.type_f == noc_pkg::HEAD_FLIT);
    // A packet ends on a tail flit, or on a head flit that has no followers.
    assign front_last = (front.body.type_f == noc_pkg::TAIL_FLIT) ||
                        (front_head && (front.head.pkt_size == noc_pkg::MIN_SIZE_FLIT));

    // A head flit routes itself; later flits follow the latched route.
    assign cur_dest  = front_head ? front.head.dest : route_q;
    assign front_vld = (count_q != '0) && (front_head || route_vld_q);

    // Only the routed output can return ready, so an OR is enough here.
    always_comb begin
      out_rdy = 1'b0;
      for (int o = 0; o < noc_pkg::N_PORTS; o++) begin
        out_rdy = out_rdy | om_resp_i[o][i].ready;
      end
    end

    // Memory writes carry no reset.
    always_ff @(posedge clk) begin
      if (push) begin
        mem_data_q[wr_ptr_q] <= in_req_i[i].fdata;
        mem_vc_q[wr_ptr_q]   <= in_req_i[i].vc_id;
      end
    end

    always_ff @(posedge clk) begin
      if (reset_i) begin
        wr_ptr_q    <= '0;
        rd_ptr_q    <= '0;
        count_q     <= '0;
        ready_q     <= 1'b0;
        route_q     <= '0;
        route_vld_q <= 1'b0;
      end else begin
        count_q <= count_nxt;
        // Ready for the next cycle is taken from the count that cycle will see.
        ready_q <= (count_nxt < noc_pkg::FIFO_DEPTH);
        if (push) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
          if (front_head) begin
            route_q     <= front.head.dest;
            route_vld_q <= !front_last;
          end else if (front_last) begin
            route_vld_q <= 1'b0;
          end
        end
      end
    end

    assign in_resp_o[i].ready = ready_q;

    // Data goes to every output, but valid only to the routed one.
    for (genvar o = 0; o < noc_pkg::N_PORTS; o++) begin : g_fan
      assign om_req_o[o][i].valid = front_vld && (cur_dest == o);
      assign om_req_o[o][i].vc_id = mem_vc_q[rd_ptr_q];
      assign om_req_o[o][i].fdata = front;
    end
  end

endmodule

`default_nettype wire

// File: hw/rr_arbiter.sv
// Round-robin arbiter for four requesters; a grant is locked until the packet's last flit leaves.
`timescale 1ns/1ns
`default_nettype none

module rr_arbiter (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic                         update_i,
  input  logic [noc_pkg::N_PORTS-1:0]  req_i,
  output logic [noc_pkg::N_PORTS-1:0]  grant_o
);

  // Rotating priority pointer and the locked winner.
  logic [noc_pkg::PORT_W-1:0]  ptr_q;
  logic [noc_pkg::PORT_W-1:0]  win_q;
  logic [noc_pkg::N_PORTS-1:0] grant_q;
  logic                        locked_q;

  // Candidate winner while the arbiter is idle.
  logic [noc_pkg::N_PORTS-1:0] pick;
  logic [noc_pkg::PORT_W-1:0]  pick_idx;
  logic [noc_pkg::PORT_W-1:0]  ptr_nxt;

  // Search from the pointer upward with wrap-around.
  // The loop runs from the farthest offset down, so the nearest requester is written last.
  always_comb begin : pick_next
    logic [noc_pkg::PORT_W-1:0] idx;
    pick     = '0;
    pick_idx = ptr_q;
    for (int k = noc_pkg::N_PORTS - 1; k >= 0; k--) begin
      idx = ptr_q + k[noc_pkg::PORT_W-1:0];
      if (req_i[idx]) begin
        pick     = '0;
        pick[idx] = 1'b1;
        pick_idx = idx;
      end
    end
  end

  // The pointer moves one place past whoever just finished.
  // A head-only packet may finish in the cycle it is picked, before any lock exists.
  always_comb begin : next_pointer
    int unsigned nxt;
    nxt     = int'(locked_q ? win_q : pick_idx) + 1;
    ptr_nxt = nxt[noc_pkg::PORT_W-1:0];
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ptr_q    <= '0;
      win_q    <= '0;
      grant_q  <= '0;
      locked_q <= 1'b0;
    end else if (update_i) begin
      // The last flit left, so release the channel.
      locked_q <= 1'b0;
      grant_q  <= '0;
      ptr_q    <= ptr_nxt;
    end else if (!locked_q && |req_i) begin
      // Hold the new winner until its packet is done.
      locked_q <= 1'b1;
      grant_q  <= pick;
      win_q    <= pick_idx;
    end
  end

  // An idle arbiter grants at once so a flit is not delayed by the lock.
  assign grant_o = locked_q ? grant_q : pick;

endmodule

`default_nettype wire

// File: hw/noc_pkg.sv
// Shared router constants, flit encodings and handshake structs, referenced by scoped name.
`default_nettype none

package noc_pkg;

  // Router geometry.
  // Four ports and two virtual channels per output link.
  localparam int N_PORTS    = 4;
  localparam int N_VIRT_CHN = 2;
  localparam int VC_W       = 1;
  localparam int PORT_W     = $clog2(N_PORTS);

  // When set, the higher virtual channel wins an output over a lower one.
  localparam bit H_PRIORITY = 1'b1;

  // A head flit with this size carries the whole packet by itself.
  localparam int MIN_SIZE_FLIT = 0;

  // Input and egress buffers share one depth.
  // The pointer and count widths follow from it.
  localparam int FIFO_DEPTH = 2;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // Flit type field, found in the top two bits of every flit word.
  typedef enum logic [1:0] {
    HEAD_FLIT = 2'd0,
    BODY_FLIT = 2'd1,
    TAIL_FLIT = 2'd2
  } flit_type_e;

  // Head view of a flit word.
  // The tag carries the source identity used by the sinks.
  typedef struct packed {
    flit_type_e        type_f;
    logic [PORT_W-1:0] dest;
    logic [7:0]        pkt_size;
    logic [19:0]       tag;
  } s_flit_head_t;

  // Body and tail view of a flit word.
  typedef struct packed {
    flit_type_e  type_f;
    logic [29:0] payload;
  } s_flit_body_t;

  // One 32-bit flit word, decoded as head or as body depending on type_f.
  typedef union packed {
    s_flit_head_t head;
    s_flit_body_t body;
  } flit_data_u;

  // Forward half of a valid/ready link.
  typedef struct packed {
    logic            valid;
    logic [VC_W-1:0] vc_id;
    flit_data_u      fdata;
  } s_flit_req_t;

  // Backward half of a valid/ready link.
  typedef struct packed {
    logic ready;
  } s_flit_resp_t;

endpackage

`default_nettype wire
